// File: filelist.f
source/armPkg.sv
source/hazardIf.sv
source/ctrlIf.sv
source/regfile.sv
source/alu.sv
source/controller.sv
source/hazardUnit.sv
source/datapath.sv
source/armCore.sv
tb/tbMemory.sv
tb/armCoreTb.sv

// File: tb/armCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

module armCoreTb;
  import armPkg::*;

  localparam int          ClkPeriod      = 4;
  localparam int          RomWords       = 128;
  localparam int          RamWords       = 256;
  localparam int          RamAw          = 8;
  localparam int          Blocks         = 3;
  localparam int          CyclesPerInstr = 40;
  // Enough for the last store to leave the five-stage pipe
  localparam int          DrainCycles    = 8;
  localparam logic [3:0]  RegBase        = 4'd11;
  localparam logic [31:0] Seed           = 32'd85;

  logic        clk;
  logic        rst;
  logic [31:0] instrF;
  logic [31:0] readDataM;
  logic [31:0] pcF;
  logic [31:0] dataAdrM;
  logic [31:0] writeDataM;
  logic        memWriteM;

  logic [31:0] prog [$];
  // Expected stores in program order
  logic [31:0] expAdr [$];
  logic [31:0] expData [$];
  logic [31:0] lcgState;
  logic [31:0] loopAddr;
  int          errCount;
  int          storeCount;

  armCore dut_i (
    .clk        (clk),
    .rst        (rst),
    .InstrF     (instrF),
    .ReadDataM  (readDataM),
    .PCF        (pcF),
    .DataAdrM   (dataAdrM),
    .WriteDataM (writeDataM),
    .MemWriteM  (memWriteM)
  );

  tbMemory #(.RomWords(RomWords), .RamWords(RamWords)) mem_i (
    .clk       (clk),
    .instrAdr  (pcF),
    .dataAdr   (dataAdrM),
    .writeData (writeDataM),
    .memWrite  (memWriteM),
    .instr     (instrF),
    .readData  (readDataM)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // ======================================
  // Program generation
  // ======================================
  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    // Upper half only since the low bits repeat quickly
    return {16'b0, lcgState[31:16]};
  endfunction

  function automatic logic [31:0] encDp(input logic [3:0] cond, input logic [3:0] cmd,
                                        input logic s, input logic imm,
                                        input logic [3:0] rn, input logic [3:0] rd,
                                        input logic [7:0] op2);
    return {cond, 2'b00, imm, cmd, s, rn, rd, 4'b0000, op2};
  endfunction

  // Pre-indexed with the offset added and no writeback
  function automatic logic [31:0] encMem(input logic load, input logic [3:0] rn,
                                         input logic [3:0] rd, input logic [11:0] off);
    return {CondAl, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, load, rn, rd, off};
  endfunction

  function automatic logic [31:0] encBranch(input logic [3:0] cond, input logic [23:0] off);
    return {cond, 4'b1010, off};
  endfunction

  task automatic genBlock();
    logic [3:0]  r [0:6];
    logic [31:0] start;
    logic [7:0]  base, i1, i2, i3, i4, k;
    logic [11:0] ldOff;
    int          idx;
    start = lcgNext() % 10;
    // Step of 3 over 10 registers gives seven distinct ones
    for (idx = 0; idx < 7; idx++) begin
      r[idx] = 4'(1 + (start + idx * 3) % 10);
    end
    base  = 8'((lcgNext() % 48) * 4);
    ldOff = 12'(64 + (lcgNext() % 32) * 4);
    i1    = 8'(lcgNext());
    i2    = 8'(lcgNext());
    i3    = 8'(lcgNext());
    i4    = 8'(lcgNext());
    k     = 8'(lcgNext());
    prog.push_back(encDp(CondAl, OpMov, 1'b0, 1'b1, 4'd0, RegBase, base));
    prog.push_back(encDp(CondAl, OpMov, 1'b0, 1'b1, 4'd0, r[0], i1));
    // Back-to-back chain with operands from M and W
    prog.push_back(encDp(CondAl, OpAdd, 1'b0, 1'b1, r[0], r[1], i2));
    prog.push_back(encDp(CondAl, OpSub, 1'b0, 1'b0, r[1], r[2], 8'(r[0])));
    prog.push_back(encDp(CondAl, OpOrr, 1'b0, 1'b0, r[2], r[3], 8'(r[1])));
    prog.push_back(encDp(CondAl, OpAnd, 1'b0, 1'b1, r[3], r[4], i3));
    prog.push_back(encMem(1'b0, RegBase, r[1], 12'd0));
    prog.push_back(encMem(1'b0, RegBase, r[2], 12'd4));
    prog.push_back(encMem(1'b0, RegBase, r[3], 12'd8));
    prog.push_back(encMem(1'b0, RegBase, r[4], 12'd12));
    // Load-use on the first and on the second source
    prog.push_back(encMem(1'b1, RegBase, r[0], ldOff));
    prog.push_back(encDp(CondAl, OpAdd, 1'b0, 1'b1, r[0], r[1], i4));
    prog.push_back(encMem(1'b0, RegBase, r[1], 12'd16));
    prog.push_back(encMem(1'b1, RegBase, r[2], 12'd8));
    prog.push_back(encDp(CondAl, OpSub, 1'b0, 1'b0, r[4], r[3], 8'(r[2])));
    prog.push_back(encMem(1'b0, RegBase, r[3], 12'd20));
    // Equal compare so BNE falls through and ADDNE is cancelled
    prog.push_back(encDp(CondAl, OpMov, 1'b0, 1'b1, 4'd0, r[5], k));
    prog.push_back(encDp(CondAl, OpCmp, 1'b1, 1'b1, r[5], 4'd0, k));
    prog.push_back(encBranch(CondNe, 24'd1));
    prog.push_back(encDp(CondNe, OpAdd, 1'b0, 1'b1, r[0], r[0], 8'd1));
    prog.push_back(encMem(1'b0, RegBase, r[0], 12'd24));
    // BEQ jumps over the next two words
    prog.push_back(encBranch(CondEq, 24'd1));
    prog.push_back(encMem(1'b0, RegBase, r[5], 12'd28));
    prog.push_back(encDp(CondAl, OpAdd, 1'b0, 1'b1, r[0], r[0], 8'd7));
    prog.push_back(encMem(1'b0, RegBase, r[0], 12'd32));
    // ADDS clears Z and the plain SUB to zero must not set it
    prog.push_back(encDp(CondAl, OpAdd, 1'b1, 1'b1, r[5], r[6], 8'd1));
    prog.push_back(encDp(CondAl, OpSub, 1'b0, 1'b0, r[5], r[6], 8'(r[5])));
    prog.push_back(encDp(CondEq, OpAdd, 1'b0, 1'b1, r[0], r[0], 8'd3));
    prog.push_back(encDp(CondNe, OpAdd, 1'b0, 1'b1, r[1], r[1], 8'd5));
    prog.push_back(encMem(1'b0, RegBase, r[0], 12'd36));
    prog.push_back(encMem(1'b0, RegBase, r[1], 12'd40));
    prog.push_back(encMem(1'b0, RegBase, r[6], 12'd44));
  endtask

  // ======================================
  // Reference model
  // ======================================

  // Steps one instruction at a time and fills the expected store queues
  task automatic runModel();
    logic [31:0] regs [0:15];
    logic [31:0] mram [0:RamWords-1];
    logic [31:0] pc, nextPc, ins, opA, opB, res, adr;
    logic        zFlag, pass;
    int          idx, steps;
    for (idx = 0; idx < 16; idx++) begin
      regs[idx] = '0;
    end
    for (idx = 0; idx < RamWords; idx++) begin
      mram[idx] = mem_i.fillWord(32'(idx) * 4);
    end
    pc    = '0;
    zFlag = 1'b0;
    steps = 0;
    while ((pc != loopAddr) && (steps < RomWords * 4)) begin
      ins    = prog[pc[31:2]];
      nextPc = pc + 4;
      case (ins[31:28])
        CondEq:  pass = zFlag;
        CondNe:  pass = !zFlag;
        default: pass = 1'b1;
      endcase
      if (ins[27:26] == 2'b00) begin
        opA = regs[ins[19:16]];
        opB = ins[25] ? {24'b0, ins[7:0]} : regs[ins[3:0]];
        case (ins[24:21])
          OpAnd:   res = opA & opB;
          OpOrr:   res = opA | opB;
          OpAdd:   res = opA + opB;
          OpMov:   res = opB;
          // SUB and CMP
          default: res = opA - opB;
        endcase
        if (pass && (ins[24:21] != OpCmp)) begin
          regs[ins[15:12]] = res;
        end
        if (pass && (ins[20] || (ins[24:21] == OpCmp))) begin
          zFlag = (res == '0);
        end
      end else if (ins[27:26] == 2'b01) begin
        adr = regs[ins[19:16]] + {20'b0, ins[11:0]};
        if (pass && ins[20]) begin
          regs[ins[15:12]] = mram[adr[2 +: RamAw]];
        end else if (pass) begin
          mram[adr[2 +: RamAw]] = regs[ins[15:12]];
          expAdr.push_back(adr);
          expData.push_back(regs[ins[15:12]]);
        end
      end else if (pass) begin
        // Target is relative to the branch address plus 8
        nextPc = pc + 8 + {{6{ins[23]}}, ins[23:0], 2'b00};
      end
      pc = nextPc;
      steps++;
    end
  endtask

  // ======================================
  // Store checks
  // ======================================
  task automatic checkStore(input logic [31:0] adr, input logic [31:0] data);
    logic [31:0] wantAdr;
    logic [31:0] wantData;
    storeCount++;
    assert (expAdr.size() > 0) else begin
      errCount++;
      $display("Store %0d to address %h came after all expected stores", storeCount, adr);
    end
    if (expAdr.size() > 0) begin
      wantAdr  = expAdr.pop_front();
      wantData = expData.pop_front();
      assert (adr === wantAdr) else begin
        errCount++;
        $display("Error at %0t: store %0d address %h, expected %h",
                 $time, storeCount, adr, wantAdr);
      end
      assert (data === wantData) else begin
        errCount++;
        $display("Error at %0t: store %0d data %h, expected %h",
                 $time, storeCount, data, wantData);
      end
    end
  endtask

  // Registered outputs are settled by the falling edge
  always @(negedge clk) begin
    if (!rst && memWriteM) begin
      checkStore(dataAdrM, writeDataM);
    end
  end

  // Hang guard scaled by program length
  initial begin
    #1;
    repeat (prog.size() * CyclesPerInstr) @(posedge clk);
    $display("Timeout: the core did not reach the final loop in time");
    $display("Test failures found");
    $finish;
  end

  // ======================================
  // Main sequence
  // ======================================
  initial begin
    int idx;
    errCount   = 0;
    storeCount = 0;
    lcgState   = Seed;
    rst        = 1'b1;
    for (idx = 0; idx < Blocks; idx++) begin
      genBlock();
    end
    // Self-loop that also fills the unused ROM words
    prog.push_back(encBranch(CondAl, 24'hFFFFFE));
    loopAddr = 32'((prog.size() - 1) * 4);
    for (idx = 0; idx < RomWords; idx++) begin
      mem_i.rom[idx] = encBranch(CondAl, 24'hFFFFFE);
    end
    for (idx = 0; idx < prog.size(); idx++) begin
      mem_i.rom[idx] = prog[idx];
    end
    runModel();

    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    assert ((pcF === '0) && (memWriteM === 1'b0)) else begin
      errCount++;
      $display("Error at %0t: after reset PCF %h MemWriteM %b", $time, pcF, memWriteM);
    end

    while (pcF !== loopAddr) begin
      @(posedge clk);
      #1;
    end
    repeat (DrainCycles) @(posedge clk);

    assert (expAdr.size() == 0) else begin
      errCount++;
      $display("The program ended with %0d expected stores never seen", expAdr.size());
    end
    $display("Stores seen: %0d, errors: %0d", storeCount, errCount);
    if (errCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/tbMemory.sv
`timescale 1ns/100ps
`default_nettype none

module tbMemory #(
  parameter int RomWords = 128,
  parameter int RamWords = 256
) (
  input  logic        clk,
  input  logic [31:0] instrAdr,
  input  logic [31:0] dataAdr,
  input  logic [31:0] writeData,
  input  logic        memWrite,
  output logic [31:0] instr,
  output logic [31:0] readData
);

  localparam int RomAw = $clog2(RomWords);
  localparam int RamAw = $clog2(RamWords);

  // Program words, loaded before reset ends
  logic [31:0] rom [0:RomWords-1];
  logic [31:0] ram [0:RamWords-1];

  // Initial data word, mixes every address bit
  function automatic logic [31:0] fillWord(input logic [31:0] adr);
    return (adr * 32'h9E37_79B1) ^ {adr[15:0], adr[31:16]} ^ 32'h5A5A_0F0F;
  endfunction

  initial begin
    int idx;
    for (idx = 0; idx < RamWords; idx++) begin
      ram[idx] = fillWord(32'(idx) * 4);
    end
  end

  // ======================================
  // Combinational reads, word addressed
  // ======================================
  assign instr    = rom[instrAdr[2 +: RomAw]];
  assign readData = ram[dataAdr[2 +: RamAw]];

  // Store lands at the edge where the write strobe is high
  always @(posedge clk) begin
    if (memWrite) begin
      ram[dataAdr[2 +: RamAw]] <= writeData;
    end
  end

endmodule

`default_nettype wire

// File: source/armCore.sv
`timescale 1ns/100ps
`default_nettype none

module armCore (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [armPkg::DataWidth-1:0]  InstrF,
  input  logic [armPkg::DataWidth-1:0]  ReadDataM,
  output logic [armPkg::DataWidth-1:0]  PCF,
  output logic [armPkg::DataWidth-1:0]  DataAdrM,
  output logic [armPkg::DataWidth-1:0]  WriteDataM,
  output logic                          MemWriteM
);

  // Stage-tagged control and addresses for the hazard unit
  logic       regWriteM;
  logic       memtoRegE;
  logic [3:0] wa3E, wa3M, ra1E, ra2E;

  hazardIf hzIf ();
  ctrlIf   ctIf ();

  controller ctrl_i (
    .clk       (clk),
    .rst       (rst),
    .ct        (ctIf),
    .StallD    (hzIf.StallD),
    .FlushE    (hzIf.FlushE),
    .MemWriteM (MemWriteM),
    .RegWriteM (regWriteM),
    .MemtoRegE (memtoRegE),
    .WA3E      (wa3E),
    .WA3M      (wa3M),
    .RA1E      (ra1E),
    .RA2E      (ra2E)
  );

  // ALU result in M doubles as the data address
  datapath dp_i (
    .clk        (clk),
    .rst        (rst),
    .InstrF     (InstrF),
    .ReadDataM  (ReadDataM),
    .PCF        (PCF),
    .ALUOutM    (DataAdrM),
    .WriteDataM (WriteDataM),
    .hz         (hzIf),
    .ct         (ctIf)
  );

  hazardUnit hz_i (
    .hz           (hzIf),
    .RA1E         (ra1E),
    .RA2E         (ra2E),
    .WA3E         (wa3E),
    .WA3M         (wa3M),
    .WA3W         (ctIf.WA3W),
    .RegWriteM    (regWriteM),
    .RegWriteW    (ctIf.RegWriteW),
    .MemtoRegE    (memtoRegE),
    .RA1D         (ctIf.RA1D),
    .RA2D         (ctIf.RA2D),
    .BranchTakenE (ctIf.BranchTakenE)
  );

endmodule

`default_nettype wire

// File: source/datapath.sv
`timescale 1ns/100ps
`default_nettype none

module datapath (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [armPkg::DataWidth-1:0]  InstrF,
  input  logic [armPkg::DataWidth-1:0]  ReadDataM,
  output logic [armPkg::DataWidth-1:0]  PCF,
  output logic [armPkg::DataWidth-1:0]  ALUOutM,
  output logic [armPkg::DataWidth-1:0]  WriteDataM,
  hazardIf.dp                           hz,
  ctrlIf.dp                             ct
);
  import armPkg::*;

  logic [DataWidth-1:0] pcPlus4F, pcNextF;
  logic [DataWidth-1:0] pcPlus4D, pcPlus8D, extImmD, rd1D, rd2D;
  logic [DataWidth-1:0] rd1E, rd2E, extImmE;
  logic [DataWidth-1:0] srcAE, srcBE, writeDataE, aluResultE;
  logic [DataWidth-1:0] aluOutW, readDataW, resultW;

  // Three-way operand select shared by both E forward paths
  function automatic logic [DataWidth-1:0] fwdMux(input fwdSelT sel,
                                                  input logic [DataWidth-1:0] regVal,
                                                  input logic [DataWidth-1:0] wbVal,
                                                  input logic [DataWidth-1:0] memVal);
    case (sel)
      FwdWb:   return wbVal;
      FwdMem:  return memVal;
      default: return regVal;
    endcase
  endfunction

  // ======================================
  // Fetch
  // ======================================
  assign pcPlus4F = PCF + DataWidth'(4);
  // Branch target from the ALU wins over sequential fetch
  assign pcNextF  = ct.BranchTakenE ? aluResultE : pcPlus4F;

  always_ff @(posedge clk) begin
    if (rst) begin
      PCF <= '0;
    end else if (!hz.StallF) begin
      PCF <= pcNextF;
    end
  end

  // ======================================
  // Decode
  // ======================================

  // A flushed slot holds ANDEQ r0, r0, r0 which leaves r0 unchanged
  always_ff @(posedge clk) begin
    if (rst || hz.FlushD) begin
      ct.InstrD <= '0;
      pcPlus4D  <= '0;
    end else if (!hz.StallD) begin
      ct.InstrD <= InstrF;
      pcPlus4D  <= pcPlus4F;
    end
  end

  // r15 reads as the D instruction address plus 8
  assign pcPlus8D = pcPlus4D + DataWidth'(4);

  regfile rf_i (
    .clk      (clk),
    .RegWrite (ct.RegWriteW),
    .RA1      (ct.RA1D),
    .RA2      (ct.RA2D),
    .WA3      (ct.WA3W),
    .WD3      (resultW),
    .R15      (pcPlus8D),
    .RD1      (rd1D),
    .RD2      (rd2D)
  );

  // Immediate extend, no rotate
  always_comb begin
    case (ct.ImmSrcD)
      ImmDp:     extImmD = {24'b0, ct.InstrD[7:0]};
      ImmMem:    extImmD = {20'b0, ct.InstrD[11:0]};
      // Signed word offset
      ImmBranch: extImmD = {{6{ct.InstrD[23]}}, ct.InstrD[23:0], 2'b00};
      default:   extImmD = '0;
    endcase
  end

  // ======================================
  // Execute
  // ======================================
  always_ff @(posedge clk) begin
    if (hz.FlushE) begin
      rd1E    <= '0;
      rd2E    <= '0;
      extImmE <= '0;
    end else begin
      rd1E    <= rd1D;
      rd2E    <= rd2D;
      extImmE <= extImmD;
    end
  end

  assign srcAE      = fwdMux(hz.ForwardAE, rd1E, resultW, ALUOutM);
  assign writeDataE = fwdMux(hz.ForwardBE, rd2E, resultW, ALUOutM);
  assign srcBE      = ct.ALUSrcE ? extImmE : writeDataE;

  alu alu_i (
    .SrcA       (srcAE),
    .SrcB       (srcBE),
    .ALUControl (ct.ALUControlE),
    .Result     (aluResultE),
    .Flags      (ct.ALUFlagsE)
  );

  // ======================================
  // Memory
  // ======================================
  always_ff @(posedge clk) begin
    ALUOutM    <= aluResultE;
    WriteDataM <= writeDataE;
  end

  // ======================================
  // Writeback
  // ======================================
  always_ff @(posedge clk) begin
    aluOutW   <= ALUOutM;
    readDataW <= ReadDataM;
  end

  // Feeds both the register file and the W forward path
  assign resultW = ct.MemtoRegW ? readDataW : aluOutW;

endmodule

`default_nettype wire

// File: source/hazardUnit.sv
`timescale 1ns/100ps
`default_nettype none

module hazardUnit (
  hazardIf.hazard     hz,
  input  logic [3:0]  RA1E,
  input  logic [3:0]  RA2E,
  input  logic [3:0]  WA3E,
  input  logic [3:0]  WA3M,
  input  logic [3:0]  WA3W,
  input  logic        RegWriteM,
  input  logic        RegWriteW,
  input  logic        MemtoRegE,
  input  logic [3:0]  RA1D,
  input  logic [3:0]  RA2D,
  input  logic        BranchTakenE
);
  import armPkg::*;

  logic ldrStall;

  // ======================================
  // Forwarding
  // ======================================

  // M has priority over W, r15 always comes from the PC
  function automatic fwdSelT pickFwd(input logic [3:0] ra, input logic [3:0] waM,
                                     input logic [3:0] waW, input logic wrM,
                                     input logic wrW);
    if (ra == RegPc) begin
      return FwdNone;
    end else if (wrM && (ra == waM)) begin
      return FwdMem;
    end else if (wrW && (ra == waW)) begin
      return FwdWb;
    end
    return FwdNone;
  endfunction

  assign hz.ForwardAE = pickFwd(RA1E, WA3M, WA3W, RegWriteM, RegWriteW);
  assign hz.ForwardBE = pickFwd(RA2E, WA3M, WA3W, RegWriteM, RegWriteW);

  // ======================================
  // Stall and flush
  // ======================================

  // Load in E whose result a D source needs
  assign ldrStall = MemtoRegE && ((WA3E == RA1D) || (WA3E == RA2D));

  assign hz.StallF = ldrStall;
  assign hz.StallD = ldrStall;
  // Taken branch kills the two younger instructions
  assign hz.FlushD = BranchTakenE;
  assign hz.FlushE = ldrStall || BranchTakenE;

endmodule

`default_nettype wire

// File: source/controller.sv
`timescale 1ns/100ps
`default_nettype none

module controller (
  input  logic        clk,
  input  logic        rst,
  ctrlIf.ctrl         ct,
  input  logic        StallD,
  input  logic        FlushE,
  output logic        MemWriteM,
  output logic        RegWriteM,
  output logic        MemtoRegE,
  output logic [3:0]  WA3E,
  output logic [3:0]  WA3M,
  output logic [3:0]  RA1E,
  output logic [3:0]  RA2E
);
  import armPkg::*;

  instrClassT classD;
  dpOpT       cmdD;
  aluOpT      aluOpD;
  logic       regWriteD, memWriteD, memtoRegD, branchD, aluSrcD, flagWriteD;
  logic       regWriteE, memWriteE, branchE, flagWriteE, condExE;
  condT       condE;
  logic       memtoRegM;
  // NZCV
  logic [3:0] flagsReg;

  // ======================================
  // Decode
  // ======================================
  assign classD = instrClassT'(ct.InstrD[27:26]);
  assign cmdD   = dpOpT'(ct.InstrD[24:21]);

  // Branches read r15 for the PC+8 base, stores read Rd as write data
  assign ct.RA1D = (classD == ClassBranch) ? RegPc : ct.InstrD[19:16];
  assign ct.RA2D = (classD == ClassMem) ? ct.InstrD[15:12] : ct.InstrD[3:0];

  always_comb begin
    regWriteD  = 1'b0;
    memWriteD  = 1'b0;
    memtoRegD  = 1'b0;
    branchD    = 1'b0;
    aluSrcD    = 1'b1;
    flagWriteD = 1'b0;
    aluOpD     = AluAdd;
    ct.ImmSrcD = ImmDp;
    case (classD)
      ClassDp: begin
        // Bit 25 picks immediate over Rm
        aluSrcD    = ct.InstrD[25];
        regWriteD  = (cmdD != OpCmp);
        flagWriteD = ct.InstrD[20] || (cmdD == OpCmp);
        case (cmdD)
          OpAnd:        aluOpD = AluAnd;
          OpSub, OpCmp: aluOpD = AluSub;
          OpAdd:        aluOpD = AluAdd;
          OpOrr:        aluOpD = AluOrr;
          OpMov:        aluOpD = AluMov;
          default: begin
            // Unsupported command does nothing
            regWriteD  = 1'b0;
            flagWriteD = 1'b0;
          end
        endcase
      end
      ClassMem: begin
        ct.ImmSrcD = ImmMem;
        // U bit selects offset direction, L bit load versus store
        aluOpD     = ct.InstrD[23] ? AluAdd : AluSub;
        memtoRegD  = ct.InstrD[20];
        regWriteD  = ct.InstrD[20];
        memWriteD  = !ct.InstrD[20];
      end
      ClassBranch: begin
        ct.ImmSrcD = ImmBranch;
        branchD    = 1'b1;
      end
      default: ;
    endcase
    // No writes to r15
    if (ct.InstrD[15:12] == RegPc) regWriteD = 1'b0;
  end

  // ======================================
  // Execute
  // ======================================

  // A stalled D slot must not also enter E, so E gets a bubble
  always_ff @(posedge clk) begin
    if (rst || FlushE || StallD) begin
      regWriteE  <= 1'b0;
      memWriteE  <= 1'b0;
      MemtoRegE  <= 1'b0;
      branchE    <= 1'b0;
      flagWriteE <= 1'b0;
    end else begin
      regWriteE  <= regWriteD;
      memWriteE  <= memWriteD;
      MemtoRegE  <= memtoRegD;
      branchE    <= branchD;
      flagWriteE <= flagWriteD;
    end
  end

  // Payload side of the E register
  always_ff @(posedge clk) begin
    ct.ALUSrcE     <= aluSrcD;
    ct.ALUControlE <= aluOpD;
    condE          <= condT'(ct.InstrD[31:28]);
    WA3E           <= ct.InstrD[15:12];
    RA1E           <= ct.RA1D;
    RA2E           <= ct.RA2D;
  end

  // Condition check against the committed flags, Z is bit 2
  always_comb begin
    case (condE)
      CondEq:  condExE = flagsReg[2];
      CondNe:  condExE = !flagsReg[2];
      CondAl:  condExE = 1'b1;
      default: condExE = 1'b0;
    endcase
  end

  assign ct.BranchTakenE = branchE && condExE;

  always_ff @(posedge clk) begin
    if (rst) begin
      flagsReg <= '0;
    end else if (flagWriteE && condExE) begin
      flagsReg <= ct.ALUFlagsE;
    end
  end

  // ======================================
  // Memory and writeback
  // ======================================
  always_ff @(posedge clk) begin
    if (rst) begin
      RegWriteM    <= 1'b0;
      MemWriteM    <= 1'b0;
      memtoRegM    <= 1'b0;
      ct.RegWriteW <= 1'b0;
      ct.MemtoRegW <= 1'b0;
    end else begin
      // Failed condition cancels the writes here
      RegWriteM    <= regWriteE && condExE;
      MemWriteM    <= memWriteE && condExE;
      memtoRegM    <= MemtoRegE;
      ct.RegWriteW <= RegWriteM;
      ct.MemtoRegW <= memtoRegM;
    end
  end

  always_ff @(posedge clk) begin
    WA3M    <= WA3E;
    ct.WA3W <= WA3M;
  end

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
  input  logic [armPkg::DataWidth-1:0]  SrcA,
  input  logic [armPkg::DataWidth-1:0]  SrcB,
  input  armPkg::aluOpT                 ALUControl,
  output logic [armPkg::DataWidth-1:0]  Result,
  output logic [3:0]                    Flags
);
  import armPkg::*;

  logic                 subtract;
  logic [DataWidth-1:0] srcBEff;
  logic [DataWidth:0]   sum;
  logic                 carry;
  logic                 overflow;

  // Subtract as A + ~B + 1, carry out is ARM's not-borrow
  assign subtract = (ALUControl == AluSub);
  assign srcBEff  = subtract ? ~SrcB : SrcB;
  assign sum      = {1'b0, SrcA} + {1'b0, srcBEff} + {{DataWidth{1'b0}}, subtract};

  always_comb begin
    carry    = 1'b0;
    overflow = 1'b0;
    case (ALUControl)
      AluAnd: Result = SrcA & SrcB;
      AluOrr: Result = SrcA | SrcB;
      AluMov: Result = SrcB;
      AluAdd, AluSub: begin
        Result   = sum[DataWidth-1:0];
        carry    = sum[DataWidth];
        // Same-sign operands giving a result of the other sign
        overflow = (SrcA[DataWidth-1] == srcBEff[DataWidth-1]) &&
                   (Result[DataWidth-1] != SrcA[DataWidth-1]);
      end
      default: Result = '0;
    endcase
  end

  // NZCV
  assign Flags = {Result[DataWidth-1], (Result == '0), carry, overflow};

endmodule

`default_nettype wire

// File: source/regfile.sv
`timescale 1ns/100ps
`default_nettype none

module regfile (
  input  logic                          clk,
  input  logic                          RegWrite,
  input  logic [3:0]                    RA1,
  input  logic [3:0]                    RA2,
  input  logic [3:0]                    WA3,
  input  logic [armPkg::DataWidth-1:0]  WD3,
  input  logic [armPkg::DataWidth-1:0]  R15,
  output logic [armPkg::DataWidth-1:0]  RD1,
  output logic [armPkg::DataWidth-1:0]  RD2
);
  import armPkg::*;

  // r0 to r14 only, r15 lives in the PC logic
  logic [DataWidth-1:0] regs [0:14];

  // Read port with r15 substitution and write-through
  function automatic logic [DataWidth-1:0] readReg(input logic [3:0] ra);
    if (ra == RegPc) begin
      return R15;
    end else if (RegWrite && (ra == WA3)) begin
      // Same cycle write seen by D stage
      return WD3;
    end
    return regs[ra];
  endfunction

  // Writes to r15 are dropped
  always_ff @(posedge clk) begin
    if (RegWrite && (WA3 != RegPc)) begin
      regs[WA3] <= WD3;
    end
  end

  always_comb begin
    RD1 = readReg(RA1);
    RD2 = readReg(RA2);
  end

endmodule

`default_nettype wire

// File: source/ctrlIf.sv
`timescale 1ns/100ps
`default_nettype none

interface ctrlIf;
  import armPkg::*;

  // Control from the controller
  immSrcT                ImmSrcD;
  logic                  ALUSrcE;
  aluOpT                 ALUControlE;
  logic                  BranchTakenE;
  logic                  MemtoRegW;
  logic                  RegWriteW;

  // Register addresses, decoded by the controller from InstrD
  logic [3:0]            RA1D;
  logic [3:0]            RA2D;
  logic [3:0]            WA3W;

  // Status back from the datapath
  logic [DataWidth-1:0]  InstrD;
  // NZCV
  logic [3:0]            ALUFlagsE;

  modport ctrl (
    output ImmSrcD, ALUSrcE, ALUControlE, BranchTakenE, MemtoRegW, RegWriteW,
    output RA1D, RA2D, WA3W,
    input  InstrD, ALUFlagsE
  );

  modport dp (
    input  ImmSrcD, ALUSrcE, ALUControlE, BranchTakenE, MemtoRegW, RegWriteW,
    input  RA1D, RA2D, WA3W,
    output InstrD, ALUFlagsE
  );

endinterface

`default_nettype wire

// File: source/hazardIf.sv
`timescale 1ns/100ps
`default_nettype none

interface hazardIf;
  import armPkg::*;

  // Pipeline register enables, active high stall
  logic   StallF;
  logic   StallD;

  // Bubble insertion into D and E
  logic   FlushD;
  logic   FlushE;

  // Operand forwarding selects for SrcA and write data
  fwdSelT ForwardAE;
  fwdSelT ForwardBE;

  // Hazard unit side
  modport hazard (
    output StallF, StallD, FlushD, FlushE, ForwardAE, ForwardBE
  );

  // Datapath side
  modport dp (
    input  StallF, StallD, FlushD, FlushE, ForwardAE, ForwardBE
  );

endinterface

`default_nettype wire

// File: source/armPkg.sv
`default_nettype none

package armPkg;

  // ======================================
  // Widths and register numbers
  // ======================================

  // Data, address and instruction width
  localparam int DataWidth = 32;

  // Program counter register number
  localparam logic [3:0] RegPc = 4'd15;

  // ======================================
  // Instruction encodings
  // ======================================

  // Instruction class from bits 27:26
  typedef enum logic [1:0] {
    ClassDp     = 2'b00,
    ClassMem    = 2'b01,
    ClassBranch = 2'b10
  } instrClassT;

  // Data processing command field, bits 24:21
  typedef enum logic [3:0] {
    OpAnd = 4'b0000,
    OpSub = 4'b0010,
    OpAdd = 4'b0100,
    OpCmp = 4'b1010,
    OpOrr = 4'b1100,
    OpMov = 4'b1101
  } dpOpT;

  // Condition field, ARM encoding
  typedef enum logic [3:0] {
    CondEq = 4'b0000,
    CondNe = 4'b0001,
    CondAl = 4'b1110
  } condT;

  // ======================================
  // Internal selects
  // ======================================

  typedef enum logic [2:0] {AluAnd, AluSub, AluAdd, AluOrr, AluMov} aluOpT;

  // Immediate kind for the extend unit
  typedef enum logic [1:0] {ImmDp, ImmMem, ImmBranch} immSrcT;

  // Operand source for the E stage forward muxes
  typedef enum logic [1:0] {FwdNone, FwdWb, FwdMem} fwdSelT;

endpackage

`default_nettype wire
